// ==== design/busWordPkg.sv ====
package busWordPkg;

	localparam int WORD_W     = 16;
	localparam int RING_DEPTH = 64; // one cell always stays empty.
	localparam int ADDR_W     = 6;
	localparam int CREDIT_MAX = 4;
	localparam int CREDIT_W   = $clog2(CREDIT_MAX + 1);

	// frame checker states.
	localparam logic [1:0] ST_IDLE   = 2'd0;
	localparam logic [1:0] ST_DATA   = 2'd1;
	localparam logic [1:0] ST_STATUS = 2'd2;

	typedef struct packed {
		logic [4:0] rtAddr;
		logic       transmit;
		logic [4:0] subAddr;
		logic [4:0] wordCount; // zero means 32 words.
	} cmdWordT;

	typedef struct packed {
		logic [4:0] rtAddr;
		logic       messageError;
		logic       instrumentation;
		logic       serviceRequest;
		logic [2:0] reserved;
		logic       broadcastRcvd;
		logic       busy;
		logic       subsystemFlag;
		logic       dynBusAccept;
		logic       terminalFlag;
	} statusWordT;

	// A command-sync word opens a message as a command and closes it as a status,
	// so the same 16 bits are decoded both ways.
	typedef union packed {
		cmdWordT           cmd;
		statusWordT        status;
		logic [WORD_W-1:0] raw;
	} busWordU;

endpackage

// ==== design/frameChecker.sv ====
`timescale 1ns/1ps

module frameChecker (
	input  logic                          clk,
	input  logic                          arstN,
	input  logic                          inValid,
	input  logic [busWordPkg::WORD_W-1:0] inWord,
	input  logic                          inIsCommand,
	input  logic                          inParityErr,
	input  logic                          spaceFree,
	output logic                          open,
	output logic                          commit,
	output logic                          rollback,
	output logic                          pushReq,
	output logic [busWordPkg::WORD_W-1:0] pushWord,
	output logic [7:0]                    droppedCount
);
	import busWordPkg::*;

	busWordU    inBus;
	logic [1:0] state;
	logic [4:0] cmdRt;       // terminal address of the open message.
	logic [5:0] wordsLeft;   // data words still expected.
	logic       bad;
	logic       pushPending;
	logic       spaceLost;
	logic       badNow;
	logic       statusGood;
	logic       startCmd;

	assign inBus.raw = inWord;

	// the push goes out one cycle after the word, only if a cell is free.
	assign pushReq   = pushPending & spaceFree;
	assign spaceLost = pushPending & ~spaceFree;
	assign badNow    = bad | spaceLost; // includes a push failing right now.

	assign statusGood = !badNow && !inParityErr && !inBus.status.messageError &&
		(inBus.status.rtAddr == cmdRt);

	// a clean command outside the status slot always opens a message.
	assign startCmd = inValid && inIsCommand && !inParityErr && (state != ST_STATUS);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state       <= ST_IDLE;
			cmdRt       <= '0;
			wordsLeft   <= '0;
			bad         <= 1'b0;
			pushPending <= 1'b0;
			open        <= 1'b0;
			commit      <= 1'b0;
			rollback    <= 1'b0;
		end else begin
			open        <= 1'b0;
			commit      <= 1'b0;
			rollback    <= 1'b0;
			pushPending <= 1'b0;
			if (spaceLost)
				bad <= 1'b1;

			if (inValid) begin
				case (state)
					ST_IDLE: begin
						// stray data words between messages are ignored.
					end
					ST_DATA: begin
						if (inIsCommand) begin
							rollback <= 1'b1; // message cut short.
							state    <= ST_IDLE;
						end else begin
							if (inParityErr)
								bad <= 1'b1;
							else
								pushPending <= 1'b1;
							wordsLeft <= wordsLeft - 6'd1;
							if (wordsLeft == 6'd1)
								state <= ST_STATUS;
						end
					end
					ST_STATUS: begin
						// a data word here overruns the message and ends it.
						state <= ST_IDLE;
						if (inIsCommand && statusGood)
							commit <= 1'b1;
						else
							rollback <= 1'b1;
					end
					default: state <= ST_IDLE;
				endcase
			end

			if (startCmd) begin
				open        <= 1'b1;
				pushPending <= 1'b1; // the command word is stored too.
				bad         <= 1'b0;
				cmdRt       <= inBus.cmd.rtAddr;
				wordsLeft   <= (inBus.cmd.wordCount == '0) ? 6'd32 : {1'b0, inBus.cmd.wordCount};
				state       <= ST_DATA;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (inValid)
			pushWord <= inWord;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			droppedCount <= '0;
		else if (rollback && droppedCount != 8'hFF)
			droppedCount <= droppedCount + 8'd1; // saturates.
	end

endmodule

// ==== design/ringBuffer.sv ====
`timescale 1ns/1ps

module ringBuffer (
	input  logic                          clk,
	input  logic                          arstN,
	input  logic                          open,
	input  logic                          commit,
	input  logic                          rollback,
	input  logic                          pushReq,
	input  logic [busWordPkg::WORD_W-1:0] pushWord,
	input  logic                          popReq,
	output logic                          spaceFree,
	output logic [busWordPkg::ADDR_W-1:0] committedCount,
	output logic                          popDone,
	output logic [busWordPkg::WORD_W-1:0] popWord,
	output logic                          wReq,
	output logic [busWordPkg::ADDR_W-1:0] wAddr,
	output logic [busWordPkg::WORD_W-1:0] wData,
	output logic                          rReq,
	output logic [busWordPkg::ADDR_W-1:0] rAddr,
	input  logic                          wDone,
	input  logic                          rDone,
	input  logic [busWordPkg::WORD_W-1:0] rData
);
	import busWordPkg::*;

	logic [ADDR_W-1:0] rdPtr;
	logic [ADDR_W-1:0] wrPtr;
	logic [ADDR_W-1:0] commitPtr;
	logic [ADDR_W-1:0] wrBase;

	function automatic logic [ADDR_W-1:0] nextPtr(input logic [ADDR_W-1:0] ptr);
		return (ptr == ADDR_W'(RING_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	function automatic logic [ADDR_W-1:0] distance(input logic [ADDR_W-1:0] from,
		input logic [ADDR_W-1:0] to);
		int diff;
		diff = int'(to) - int'(from);
		if (diff < 0)
			diff = diff + RING_DEPTH;
		return ADDR_W'(diff);
	endfunction

	// open or rollback restart the transaction at the commit point,
	// and a push in the same cycle already lands there.
	assign wrBase = (open | rollback) ? commitPtr : wrPtr;

	assign spaceFree      = (nextPtr(wrBase) != rdPtr);
	assign committedCount = distance(rdPtr, commitPtr);

	assign wReq  = pushReq;
	assign wAddr = wrBase;
	assign wData = pushWord;

	assign rReq  = popReq && (committedCount != '0); // never read past the commit point.
	assign rAddr = rdPtr;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			rdPtr     <= '0;
			wrPtr     <= '0;
			commitPtr <= '0;
			popDone   <= 1'b0;
		end else begin
			if (rReq)
				rdPtr <= nextPtr(rdPtr);

			if (wReq)
				wrPtr <= nextPtr(wrBase);
			else if (open | rollback)
				wrPtr <= commitPtr; // drop uncommitted words.

			// the last push of a message is written before its status word.
			if (commit)
				commitPtr <= wrPtr;

			popDone <= rDone;
		end
	end

	always_ff @(posedge clk) begin
		if (rDone)
			popWord <= rData;
	end

endmodule

// ==== design/wordRam.sv ====
`timescale 1ns/1ps

module wordRam (
	input  logic                          clk,
	input  logic                          wReq,
	input  logic [busWordPkg::ADDR_W-1:0] wAddr,
	input  logic [busWordPkg::WORD_W-1:0] wData,
	input  logic                          rReq,
	input  logic [busWordPkg::ADDR_W-1:0] rAddr,
	output logic                          wDone,
	output logic                          rDone,
	output logic [busWordPkg::WORD_W-1:0] rData,
	input  logic                          arstN
);
	import busWordPkg::*;

	logic [WORD_W-1:0] mem [RING_DEPTH];

	always_ff @(posedge clk) begin
		if (wReq)
			mem[wAddr] <= wData;
		if (rReq)
			rData <= mem[rAddr]; // valid together with rDone.
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wDone <= 1'b0;
			rDone <= 1'b0;
		end else begin
			wDone <= wReq; // one pulse per request.
			rDone <= rReq;
		end
	end

endmodule

// ==== design/egressSender.sv ====
`timescale 1ns/1ps

module egressSender (
	input  logic                          clk,
	input  logic                          arstN,
	input  logic [busWordPkg::ADDR_W-1:0] committedCount,
	input  logic                          popDone,
	input  logic [busWordPkg::WORD_W-1:0] popWord,
	input  logic                          creditReturn,
	output logic                          popReq,
	output logic                          outValid,
	output logic [busWordPkg::WORD_W-1:0] outWord
);
	import busWordPkg::*;

	logic [CREDIT_W-1:0] credits;
	logic                popPending; // held until the word leaves on outValid.

	// Pending stays set through outValid, so the credit a word uses is
	// already taken off before the next pop can start.
	assign popReq = (committedCount != '0) && (credits != '0) && !popPending;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			credits    <= CREDIT_W'(CREDIT_MAX);
			popPending <= 1'b0;
			outValid   <= 1'b0;
		end else begin
			outValid <= popDone;

			if (popReq)
				popPending <= 1'b1;
			else if (outValid)
				popPending <= 1'b0;

			case ({outValid, creditReturn})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits; // both or neither.
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (popDone)
			outWord <= popWord;
	end

endmodule

// ==== design/monitorBuffer.sv ====
`timescale 1ns/1ps

module monitorBuffer (
	input  logic                          clk,
	input  logic                          arstN,
	input  logic                          inValid,
	input  logic [busWordPkg::WORD_W-1:0] inWord,
	input  logic                          inIsCommand,
	input  logic                          inParityErr,
	input  logic                          creditReturn,
	output logic                          outValid,
	output logic [busWordPkg::WORD_W-1:0] outWord,
	output logic [7:0]                    droppedCount
);
	import busWordPkg::*;

	// transaction control and push path.
	logic              open;
	logic              commit;
	logic              rollback;
	logic              pushReq;
	logic [WORD_W-1:0] pushWord;
	logic              spaceFree;

	// memory ports.
	logic              wReq;
	logic [ADDR_W-1:0] wAddr;
	logic [WORD_W-1:0] wData;
	logic              wDone;
	logic              rReq;
	logic [ADDR_W-1:0] rAddr;
	logic              rDone;
	logic [WORD_W-1:0] rData;

	// pop path.
	logic [ADDR_W-1:0] committedCount;
	logic              popReq;
	logic              popDone;
	logic [WORD_W-1:0] popWord;

	frameChecker frameCheck (
		.clk, .arstN, .inValid, .inWord, .inIsCommand, .inParityErr,
		.spaceFree, .open, .commit, .rollback, .pushReq, .pushWord, .droppedCount
	);

	ringBuffer ring (
		.clk, .arstN, .open, .commit, .rollback, .pushReq, .pushWord, .popReq,
		.spaceFree, .committedCount, .popDone, .popWord,
		.wReq, .wAddr, .wData, .rReq, .rAddr, .wDone, .rDone, .rData
	);

	wordRam ram (
		.clk, .wReq, .wAddr, .wData, .rReq, .rAddr,
		.wDone, .rDone, .rData, .arstN
	);

	egressSender egress (
		.clk, .arstN, .committedCount, .popDone, .popWord, .creditReturn,
		.popReq, .outValid, .outWord
	);

endmodule

// ==== testbench/monitorBuffer_assert.sv ====
`timescale 1ns/1ps

module monitorBufferAssert (
	input logic                          clk,
	input logic                          arstN,
	input logic                          commit,
	input logic                          rollback,
	input logic                          pushReq,
	input logic [busWordPkg::ADDR_W-1:0] wAddr,
	input logic [busWordPkg::ADDR_W-1:0] rAddr,
	input logic [busWordPkg::ADDR_W-1:0] committedCount,
	input logic                          outValid,
	input logic                          creditReturn
);
	import busWordPkg::*;

	logic [3:0]        creditModel; // tracks the egress credit counter.
	logic [ADDR_W-1:0] writeOffset; // cells from the read pointer to the write.

	assign writeOffset = ADDR_W'(wAddr - rAddr);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			creditModel <= 4'(CREDIT_MAX);
		else
			creditModel <= creditModel - {3'b0, outValid} + {3'b0, creditReturn};
	end

	commitRollbackExclusive: assert property (@(posedge clk) disable iff (!arstN)
		!(commit && rollback))
		else $error("commit and rollback asserted in the same cycle");

	outputNeedsCredit: assert property (@(posedge clk) disable iff (!arstN)
		outValid |-> (creditModel != 4'd0))
		else $error("outValid raised with no credit left");

	// a push lands past the unread committed words and leaves one cell empty.
	pushNeedsSpace: assert property (@(posedge clk) disable iff (!arstN)
		pushReq |-> ((writeOffset >= committedCount) &&
			(writeOffset != ADDR_W'(RING_DEPTH - 1))))
		else $error("pushReq issued while the ring buffer is full");

endmodule

bind monitorBuffer monitorBufferAssert checks (
	.clk, .arstN, .commit, .rollback, .pushReq, .wAddr, .rAddr, .committedCount,
	.outValid, .creditReturn
);

// ==== testbench/monitorBufferTb.sv ====
`timescale 1ns/1ps

module monitorBufferTb;
	import busWordPkg::*;

	logic              clk = 1'b0;
	logic              arstN;
	logic              inValid;
	logic [WORD_W-1:0] inWord;
	logic              inIsCommand;
	logic              inParityErr;
	logic              creditReturn = 1'b0;
	logic              outValid;
	logic [WORD_W-1:0] outWord;
	logic [7:0]        droppedCount;

	busWordU    received[$];
	busWordU    expected[$];
	int         owed = 0;       // credits held by the consumer.
	bit         creditsEnabled;
	int         seed;
	int         wordErrors;
	int         countErrors;
	int         timeoutErrors;
	logic [7:0] dropBase;

	monitorBuffer dut (
		.clk, .arstN, .inValid, .inWord, .inIsCommand, .inParityErr,
		.creditReturn, .outValid, .outWord, .droppedCount
	);

	always #5 clk = ~clk;

	// consumer model, one credit back per cycle while enabled.
	always @(negedge clk) begin
		if (outValid) begin
			received.push_back(busWordU'(outWord));
			owed = owed + 1;
		end
		if (creditsEnabled && owed > 0) begin
			creditReturn = 1'b1;
			owed         = owed - 1;
		end else begin
			creditReturn = 1'b0;
		end
	end

	function automatic busWordU makeCmd(input logic [4:0] rt, input logic [4:0] wc);
		busWordU w;
		w.raw           = '0;
		w.cmd.rtAddr    = rt;
		w.cmd.subAddr   = 5'd1;
		w.cmd.wordCount = wc;
		return w;
	endfunction

	function automatic busWordU makeStatus(input logic [4:0] rt, input logic msgErr);
		busWordU w;
		w.raw                 = '0;
		w.status.rtAddr       = rt;
		w.status.messageError = msgErr;
		return w;
	endfunction

	task automatic checkWord(input string name, input busWordU exp, input busWordU act);
		if (act.raw !== exp.raw) begin
			$display("error %s: expected %h actual %h", name, exp.raw, act.raw);
			wordErrors++;
		end
	endtask

	task automatic checkCount(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			$display("error %s: expected %0d actual %0d", name, exp, act);
			countErrors++;
		end
	endtask

	task automatic idle(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic sendWord(input busWordU w, input logic isCmd, input logic parErr);
		@(negedge clk);
		inValid     = 1'b1;
		inWord      = w.raw;
		inIsCommand = isCmd;
		inParityErr = parErr;
		@(negedge clk);
		inValid     = 1'b0;
		inParityErr = 1'b0;
	endtask

	// whole message, queued as expected output when it should commit.
	task automatic sendMessage(input logic [4:0] rt, input logic [4:0] wc,
		input logic [4:0] statusRt, input logic msgErr, input bit keep);
		busWordU w;
		int      n;
		int      i;
		n = (wc == 5'd0) ? 32 : int'(wc);
		w = makeCmd(rt, wc);
		sendWord(w, 1'b1, 1'b0);
		if (keep)
			expected.push_back(w);
		for (i = 0; i < n; i++) begin
			w.raw = WORD_W'($random(seed));
			sendWord(w, 1'b0, 1'b0);
			if (keep)
				expected.push_back(w);
		end
		sendWord(makeStatus(statusRt, msgErr), 1'b1, 1'b0);
	endtask

	task automatic waitOutputs(input int n, input string name);
		int cycles;
		cycles = 0;
		while (received.size() < n && cycles < 2000) begin
			@(negedge clk);
			cycles++;
		end
		if (received.size() < n) begin
			$display("%s: timed out waiting for %0d output words, only %0d arrived",
				name, n, received.size());
			timeoutErrors++;
		end
	endtask

	task automatic waitDropped(input logic [7:0] value, input string name);
		int cycles;
		cycles = 0;
		while (droppedCount != value && cycles < 2000) begin
			@(negedge clk);
			cycles++;
		end
		if (droppedCount != value) begin
			$display("%s: timed out waiting for the dropped count to reach %0d", name, value);
			timeoutErrors++;
		end
	endtask

	// quiet period afterwards catches stray extra words.
	task automatic checkOutputs(input string name);
		int i;
		waitOutputs(expected.size(), name);
		idle(30);
		checkCount({name, " word count"}, 8'(expected.size()), 8'(received.size()));
		for (i = 0; i < expected.size() && i < received.size(); i++)
			checkWord(name, expected[i], received[i]);
	endtask

	task automatic startTest();
		received.delete();
		expected.delete();
		dropBase = droppedCount;
	endtask

	task automatic goodMessage();
		startTest();
		sendMessage(5'd5, 5'd3, 5'd5, 1'b0, 1'b1);
		checkOutputs("goodMessage");
		checkCount("goodMessage dropped", 8'd0, droppedCount);
	endtask

	task automatic statusReject();
		startTest();
		sendMessage(5'd7, 5'd1, 5'd7, 1'b1, 1'b0);  // message error flag.
		sendMessage(5'd9, 5'd2, 5'd10, 1'b0, 1'b0); // wrong terminal answers.
		waitDropped(dropBase + 8'd2, "statusReject");
		checkOutputs("statusReject");
		checkCount("statusReject dropped", dropBase + 8'd2, droppedCount);
	endtask

	task automatic parityAndOrder();
		busWordU w;
		startTest();
		w.raw = WORD_W'($random(seed));
		sendWord(makeCmd(5'd3, 5'd2), 1'b1, 1'b0);
		sendWord(w, 1'b0, 1'b0);
		sendWord(w, 1'b0, 1'b1); // parity error.
		sendWord(makeStatus(5'd3, 1'b0), 1'b1, 1'b0);
		sendWord(makeCmd(5'd4, 5'd1), 1'b1, 1'b0);
		sendWord(w, 1'b0, 1'b0);
		sendWord(w, 1'b0, 1'b0); // data in the status slot.
		sendWord(makeCmd(5'd6, 5'd3), 1'b1, 1'b0);
		sendWord(w, 1'b0, 1'b0);
		// this command cuts the one above short.
		sendMessage(5'd8, 5'd2, 5'd8, 1'b0, 1'b1);
		waitDropped(dropBase + 8'd3, "parityAndOrder");
		checkOutputs("parityAndOrder");
		checkCount("parityAndOrder dropped", dropBase + 8'd3, droppedCount);
	endtask

	task automatic fullCount();
		startTest();
		sendMessage(5'd12, 5'd0, 5'd12, 1'b0, 1'b1); // 32 data words.
		checkOutputs("fullCount");
	endtask

	task automatic creditBackPressure();
		startTest();
		creditsEnabled = 1'b0;
		sendMessage(5'd14, 5'd7, 5'd14, 1'b0, 1'b1);
		waitOutputs(CREDIT_MAX, "creditBackPressure");
		idle(40);
		checkCount("creditBackPressure stalled", 8'(CREDIT_MAX), 8'(received.size()));
		creditsEnabled = 1'b1;
		checkOutputs("creditBackPressure");
	endtask

	task automatic overflowDrop();
		startTest();
		creditsEnabled = 1'b0;
		// short message first, so the consumer holds all credits.
		sendMessage(5'd16, 5'd3, 5'd16, 1'b0, 1'b1);
		waitOutputs(CREDIT_MAX, "overflowDrop");
		sendMessage(5'd17, 5'd0, 5'd17, 1'b0, 1'b1);
		sendMessage(5'd18, 5'd0, 5'd18, 1'b0, 1'b0); // 66 words in 63 cells.
		waitDropped(dropBase + 8'd1, "overflowDrop");
		checkCount("overflowDrop held", 8'(CREDIT_MAX), 8'(received.size()));
		creditsEnabled = 1'b1;
		sendMessage(5'd19, 5'd2, 5'd19, 1'b0, 1'b1);
		checkOutputs("overflowDrop");
		checkCount("overflowDrop dropped", dropBase + 8'd1, droppedCount);
	endtask

	initial begin
		seed           = 8;
		creditsEnabled = 1'b1;
		wordErrors     = 0;
		countErrors    = 0;
		timeoutErrors  = 0;
		arstN          = 1'b0;
		inValid        = 1'b0;
		inWord         = '0;
		inIsCommand    = 1'b0;
		inParityErr    = 1'b0;
		repeat (3) @(negedge clk);
		arstN = 1'b1;

		goodMessage();
		statusReject();
		parityAndOrder();
		fullCount();
		creditBackPressure();
		overflowDrop();

		$display("word errors %0d, count errors %0d, timeouts %0d",
			wordErrors, countErrors, timeoutErrors);
		if (wordErrors + countErrors + timeoutErrors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== filelist.f ====
design/busWordPkg.sv
design/frameChecker.sv
design/ringBuffer.sv
design/wordRam.sv
design/egressSender.sv
design/monitorBuffer.sv
testbench/monitorBuffer_assert.sv
testbench/monitorBufferTb.sv

// ==== Makefile ====
TOP := monitorBufferTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log
